// ==== logic/usb_rx_defs.svh ====
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// Payload buffer size in bytes
`define ULPI_RX_BUF_DEPTH 64

// Buffer address width, log2 of the depth
`define ULPI_RX_BUF_AW 6

// CRC16 register contents after a good data packet, CRC bytes included.
// The register is kept in the reflected (LSB first) form, so this is the
// bit reverse of the 16'h800d residue given in the USB spec
`define USB_CRC16_RESIDUE 16'hb001

// RX_CMD bits 5:4 while the PHY is receiving a packet
`define ULPI_RXCMD_ACTIVE 2'b01

`endif

// ==== logic/usb_crc.svh ====
`ifndef USB_CRC_SVH
`define USB_CRC_SVH

// USB CRC5 over the 11 token bits, sent LSB first.
// Returns the complemented CRC in the order it sits in bits 7:3
// of the second token byte
function automatic logic [4:0] crc5(input logic [10:0] d);
  logic [4:0] r;
  r = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    if (r[0] ^ d[i]) begin
      r = (r >> 1) ^ 5'h14;
    end else begin
      r = r >> 1;
    end
  end
  return ~r;
endfunction

// One byte step of the reflected USB CRC16, start from 16'hffff.
// A sender transmits the complement of the result, low byte first
function automatic logic [15:0] crc16(input logic [7:0] d, input logic [15:0] c);
  logic [15:0] r;
  r = c;
  for (int i = 0; i < 8; i++) begin
    if (r[0] ^ d[i]) begin
      r = (r >> 1) ^ 16'ha001;
    end else begin
      r = r >> 1;
    end
  end
  return r;
endfunction

`endif

// ==== logic/usb_rx_pkg.sv ====
`include "usb_rx_defs.svh"

package usb_rx_pkg;

  // USB PIDs, low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_PING  = 4'b0100
  } usb_pid_e;

  // PID type from its two low bits
  typedef enum logic [1:0] {
    GRP_SPECIAL   = 2'b00,
    GRP_TOKEN     = 2'b01,
    GRP_HANDSHAKE = 2'b10,
    GRP_DATA      = 2'b11
  } pid_group_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PID,
    RX_BODY
  } rx_state_e;

  // Registered ULPI pins
  typedef struct packed {
    logic       dir;
    logic       nxt;
    logic [7:0] data;
  } ulpi_bus_t;

  // Fields of the last RX_CMD byte
  typedef struct packed {
    logic [1:0] line_state;
    logic [1:0] vbus_state;
    logic [1:0] rx_event;
  } phy_status_t;

  typedef struct packed {
    logic       valid;
    logic       keep;
    logic       last;
    usb_pid_e   pid;
    logic [7:0] data;
  } usb_stream_t;

  // For SOF, {endp, addr} is the frame number
  typedef struct packed {
    usb_pid_e   pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_token_t;

  typedef struct packed {
    usb_pid_e                  pid;
    logic [`ULPI_RX_BUF_AW:0]  length;
  } usb_pkt_info_t;

endpackage

// ==== logic/ulpi_phy_input.sv ====
`timescale 1ns/1ps

module ulpi_phy_input (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ulpi_dir_i,
  input  logic                    ulpi_nxt_i,
  input  logic [7:0]              ulpi_data_i,
  output usb_rx_pkg::ulpi_bus_t   bus_o,
  output logic                    ibuf_dir_o,
  output usb_rx_pkg::phy_status_t phy_status_o
);

  logic       dir_q;
  logic       nxt_q;
  logic [7:0] data_q;
  logic       dir_prev_q;
  logic       rx_cmd;

  usb_rx_pkg::phy_status_t status_q;

  // Pin flops, as the IOB registers would be
  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q      <= 1'b0;
      nxt_q      <= 1'b0;
      dir_prev_q <= 1'b0;
    end else begin
      dir_q      <= ulpi_dir_i;
      nxt_q      <= ulpi_nxt_i;
      dir_prev_q <= dir_q;
    end
  end

  always_ff @(posedge clock) begin
    data_q <= ulpi_data_i;
  end

  // Status byte: PHY owns the bus, no nxt, and not a turnaround cycle
  assign rx_cmd = dir_q && !nxt_q && dir_prev_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      status_q <= '0;
    end else if (rx_cmd) begin
      status_q.line_state <= data_q[1:0];
      status_q.vbus_state <= data_q[3:2];
      status_q.rx_event   <= data_q[5:4];
    end
  end

  assign bus_o.dir    = dir_q;
  assign bus_o.nxt    = nxt_q;
  assign bus_o.data   = data_q;
  // Unregistered dir lets the decoder see the end of a packet a cycle early
  assign ibuf_dir_o   = ulpi_dir_i;
  assign phy_status_o = status_q;

endmodule

// ==== logic/ulpi_decoder.sv ====
`timescale 1ns/1ps
`include "usb_rx_defs.svh"

module ulpi_decoder (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_rx_pkg::ulpi_bus_t   bus_i,
  input  logic                    ibuf_dir_i,
  output usb_rx_pkg::usb_stream_t stream_o,
  output usb_rx_pkg::usb_token_t  token_o,
  output logic                    tok_recv_o,
  output logic                    sof_recv_o,
  output logic                    hsk_recv_o,
  output usb_rx_pkg::usb_pid_e    hsk_pid_o,
  output logic                    data_good_o,
  output logic                    crc_error_o,
  output logic                    crc_valid_o,
  output logic                    decode_idle_o
);

  `include "usb_crc.svh"

  usb_rx_pkg::rx_state_e  state_q;
  usb_rx_pkg::usb_pid_e   pid_q;
  usb_rx_pkg::usb_pid_e   pid_in;
  usb_rx_pkg::pid_group_e grp_q;
  usb_rx_pkg::usb_token_t token_q;
  usb_rx_pkg::usb_pid_e   hsk_pid_q;

  logic        dir_q;
  logic        pid_ok_q;
  logic [7:0]  hold_q;
  logic [15:0] tok_data_q;
  logic [1:0]  tok_cnt_q;
  logic [15:0] crc16_q;

  // Stream beat registers
  logic        st_valid_q;
  logic        st_keep_q;
  logic        st_last_q;
  logic [7:0]  st_data_q;

  // Result strobes
  logic tok_recv_q;
  logic sof_recv_q;
  logic hsk_end_q;
  logic hsk_recv_q;
  logic data_good_q;
  logic crc_error_q;
  logic crc_valid_q;

  logic rx_byte;
  logic rx_end;
  logic in_pkt;
  logic pkt_end;
  logic accept_pid;
  logic body_byte;
  logic is_tok;
  logic is_sof;
  logic is_data;
  logic is_hsk;
  logic tok_good;
  logic crc16_ok;

  // Skip the turnaround cycle after dir rises
  assign rx_byte = bus_i.dir && bus_i.nxt && dir_q;

  // RxActive dropped in an RX_CMD, or the PHY released the bus
  assign rx_end = (bus_i.dir && !bus_i.nxt && dir_q &&
                   bus_i.data[5:4] != `ULPI_RXCMD_ACTIVE) ||
                  (!ibuf_dir_i && bus_i.dir);

  assign in_pkt     = state_q != usb_rx_pkg::RX_IDLE;
  assign pkt_end    = in_pkt && rx_end;
  assign accept_pid = !in_pkt && rx_byte && !rx_end;
  assign body_byte  = in_pkt && rx_byte && !rx_end;

  assign pid_in = usb_rx_pkg::usb_pid_e'(bus_i.data[3:0]);
  assign grp_q  = usb_rx_pkg::pid_group_e'(pid_q[1:0]);

  // Packet kind, only for a PID that matched its complement
  assign is_tok  = pid_ok_q && (grp_q == usb_rx_pkg::GRP_TOKEN ||
                                pid_q == usb_rx_pkg::PID_PING);
  assign is_sof  = pid_ok_q && pid_q == usb_rx_pkg::PID_SOF;
  assign is_data = pid_ok_q && grp_q == usb_rx_pkg::GRP_DATA;
  assign is_hsk  = pid_ok_q && grp_q == usb_rx_pkg::GRP_HANDSHAKE;

  // Exactly two bytes after the PID, CRC5 in bits 15:11
  assign tok_good = tok_cnt_q == 2'd2 && crc5(tok_data_q[10:0]) == tok_data_q[15:11];
  assign crc16_ok = crc16_q == `USB_CRC16_RESIDUE;

  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q      <= 1'b0;
      state_q    <= usb_rx_pkg::RX_IDLE;
      pid_ok_q   <= 1'b0;
      tok_cnt_q  <= 2'd0;
      st_valid_q <= 1'b0;
      st_keep_q  <= 1'b0;
      st_last_q  <= 1'b0;
    end else begin
      dir_q      <= bus_i.dir;
      st_valid_q <= 1'b0;
      st_keep_q  <= 1'b0;
      st_last_q  <= 1'b0;
      if (accept_pid) begin
        state_q   <= usb_rx_pkg::RX_PID;
        pid_ok_q  <= bus_i.data[3:0] == ~bus_i.data[7:4];
        tok_cnt_q <= 2'd0;
      end else if (pkt_end) begin
        state_q    <= usb_rx_pkg::RX_IDLE;
        st_valid_q <= pid_ok_q;
        st_last_q  <= 1'b1;
      end else if (body_byte) begin
        state_q    <= usb_rx_pkg::RX_BODY;
        // Held byte goes out now, the PID byte without keep
        st_valid_q <= pid_ok_q;
        st_keep_q  <= state_q == usb_rx_pkg::RX_BODY;
        if (tok_cnt_q != 2'd3) begin
          tok_cnt_q <= tok_cnt_q + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept_pid) begin
      pid_q <= pid_in;
    end
    if (rx_byte) begin
      hold_q <= bus_i.data;
    end
    if (body_byte) begin
      st_data_q <= hold_q;
      if (tok_cnt_q == 2'd0) begin
        tok_data_q[7:0] <= bus_i.data;
      end else if (tok_cnt_q == 2'd1) begin
        tok_data_q[15:8] <= bus_i.data;
      end
    end
    // Running CRC16 over everything after the PID
    if (!in_pkt) begin
      crc16_q <= 16'hffff;
    end else if (body_byte) begin
      crc16_q <= crc16(bus_i.data, crc16_q);
    end
    if (pkt_end && is_tok) begin
      token_q.pid  <= pid_q;
      token_q.addr <= tok_data_q[6:0];
      token_q.endp <= tok_data_q[10:7];
    end
    if (hsk_end_q) begin
      hsk_pid_q <= pid_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_recv_q  <= 1'b0;
      sof_recv_q  <= 1'b0;
      hsk_end_q   <= 1'b0;
      hsk_recv_q  <= 1'b0;
      data_good_q <= 1'b0;
      crc_error_q <= 1'b0;
      crc_valid_q <= 1'b0;
    end else begin
      tok_recv_q  <= pkt_end && is_tok && !is_sof && tok_good;
      sof_recv_q  <= pkt_end && is_sof && tok_good;
      data_good_q <= pkt_end && is_data && crc16_ok;
      crc_valid_q <= pkt_end && ((is_tok && tok_good) || (is_data && crc16_ok));
      crc_error_q <= pkt_end && ((is_tok && !tok_good) || (is_data && !crc16_ok));
      // Handshake is a lone PID byte
      hsk_end_q   <= pkt_end && is_hsk && state_q == usb_rx_pkg::RX_PID;
      hsk_recv_q  <= hsk_end_q;
    end
  end

  assign stream_o.valid = st_valid_q;
  assign stream_o.keep  = st_keep_q;
  assign stream_o.last  = st_last_q;
  assign stream_o.pid   = pid_q;
  assign stream_o.data  = st_data_q;

  assign token_o       = token_q;
  assign tok_recv_o    = tok_recv_q;
  assign sof_recv_o    = sof_recv_q;
  assign hsk_recv_o    = hsk_recv_q;
  assign hsk_pid_o     = hsk_pid_q;
  assign data_good_o   = data_good_q;
  assign crc_error_o   = crc_error_q;
  assign crc_valid_o   = crc_valid_q;
  assign decode_idle_o = !in_pkt;

endmodule

// ==== logic/usb_packet_buffer.sv ====
`timescale 1ns/1ps
`include "usb_rx_defs.svh"

module usb_packet_buffer #(
  parameter int DEPTH = `ULPI_RX_BUF_DEPTH
) (
  input  logic                        clock,
  input  logic                        reset,
  input  usb_rx_pkg::usb_stream_t     stream_i,
  input  logic                        data_good_i,
  output logic                        pkt_valid_o,
  output usb_rx_pkg::usb_pkt_info_t   pkt_info_o,
  input  logic [`ULPI_RX_BUF_AW-1:0]  rd_addr_i,
  output logic [7:0]                  rd_data_o
);

  logic [7:0] mem [DEPTH];
  logic [7:0] rd_data_q;

  logic [`ULPI_RX_BUF_AW:0] wr_cnt_q;
  logic [`ULPI_RX_BUF_AW:0] pay_len;
  logic                     is_data;
  logic                     pid_beat;
  logic                     wr_en;

  usb_rx_pkg::usb_pid_e      pkt_pid_q;
  usb_rx_pkg::usb_pkt_info_t info_q;
  logic                      pkt_valid_q;

  assign is_data  = usb_rx_pkg::pid_group_e'(stream_i.pid[1:0]) == usb_rx_pkg::GRP_DATA;
  assign pid_beat = stream_i.valid && !stream_i.keep && !stream_i.last;
  // Bytes past the end of memory are dropped
  assign wr_en    = stream_i.valid && stream_i.keep && is_data && wr_cnt_q < DEPTH;

  // The stream holds back the last byte of a packet, so only the first
  // CRC byte lands here
  assign pay_len = (wr_cnt_q == '0) ? '0 : wr_cnt_q - 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_cnt_q <= '0;
    end else if (pid_beat) begin
      wr_cnt_q <= '0;
    end else if (wr_en) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_cnt_q[`ULPI_RX_BUF_AW-1:0]] <= stream_i.data;
    end
    if (pid_beat) begin
      pkt_pid_q <= stream_i.pid;
    end
    rd_data_q <= mem[rd_addr_i];
  end

  // Announce only packets whose CRC16 checked out
  always_ff @(posedge clock) begin
    if (reset) begin
      pkt_valid_q <= 1'b0;
    end else begin
      pkt_valid_q <= data_good_i;
    end
  end

  always_ff @(posedge clock) begin
    if (data_good_i) begin
      info_q.pid    <= pkt_pid_q;
      info_q.length <= pay_len;
    end
  end

  assign pkt_valid_o = pkt_valid_q;
  assign pkt_info_o  = info_q;
  assign rd_data_o   = rd_data_q;

endmodule

// ==== logic/ulpi_rx_top.sv ====
`timescale 1ns/1ps
`include "usb_rx_defs.svh"

module ulpi_rx_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        ulpi_dir_i,
  input  logic                        ulpi_nxt_i,
  input  logic [7:0]                  ulpi_data_i,
  output usb_rx_pkg::phy_status_t     phy_status_o,
  output usb_rx_pkg::usb_token_t      token_o,
  output logic                        tok_recv_o,
  output logic                        sof_recv_o,
  output logic                        hsk_recv_o,
  output usb_rx_pkg::usb_pid_e        hsk_pid_o,
  output logic                        crc_error_o,
  output logic                        crc_valid_o,
  output logic                        decode_idle_o,
  output logic                        pkt_valid_o,
  output usb_rx_pkg::usb_pkt_info_t   pkt_info_o,
  input  logic [`ULPI_RX_BUF_AW-1:0]  rd_addr_i,
  output logic [7:0]                  rd_data_o
);

  usb_rx_pkg::ulpi_bus_t   bus;
  usb_rx_pkg::usb_stream_t stream;
  logic                    ibuf_dir;
  logic                    data_good;

  ulpi_phy_input u_phy_input (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .bus_o        (bus),
    .ibuf_dir_o   (ibuf_dir),
    .phy_status_o (phy_status_o)
  );

  ulpi_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .bus_i         (bus),
    .ibuf_dir_i    (ibuf_dir),
    .stream_o      (stream),
    .token_o       (token_o),
    .tok_recv_o    (tok_recv_o),
    .sof_recv_o    (sof_recv_o),
    .hsk_recv_o    (hsk_recv_o),
    .hsk_pid_o     (hsk_pid_o),
    .data_good_o   (data_good),
    .crc_error_o   (crc_error_o),
    .crc_valid_o   (crc_valid_o),
    .decode_idle_o (decode_idle_o)
  );

  usb_packet_buffer #(
    .DEPTH (`ULPI_RX_BUF_DEPTH)
  ) u_packet_buffer (
    .clock       (clock),
    .reset       (reset),
    .stream_i    (stream),
    .data_good_i (data_good),
    .pkt_valid_o (pkt_valid_o),
    .pkt_info_o  (pkt_info_o),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o)
  );

endmodule

// ==== test/ulpi_rx_assertions.sv ====
`timescale 1ns/1ps

module ulpi_rx_assertions (
  input logic clock,
  input logic reset,
  input logic crc_error_i,
  input logic crc_valid_i,
  input logic tok_recv_i,
  input logic sof_recv_i,
  input logic pkt_valid_i
);

  int fail_count = 0;

  // A CRC verdict is either good or bad
  a_crc_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(crc_error_i && crc_valid_i)
  ) else begin
    $error("crc_error and crc_valid high in the same cycle");
    fail_count++;
  end

  // Token strobes only for tokens whose CRC5 checked out
  a_token_crc: assert property (
    @(posedge clock) disable iff (reset) (tok_recv_i || sof_recv_i) |-> crc_valid_i
  ) else begin
    $error("token strobe without crc_valid");
    fail_count++;
  end

  a_pkt_after_crc: assert property (
    @(posedge clock) disable iff (reset) pkt_valid_i |-> $past(crc_valid_i)
  ) else begin
    $error("pkt_valid without crc_valid in the cycle before");
    fail_count++;
  end

endmodule

bind ulpi_rx_top ulpi_rx_assertions u_assertions (
  .clock       (clock),
  .reset       (reset),
  .crc_error_i (crc_error_o),
  .crc_valid_i (crc_valid_o),
  .tok_recv_i  (tok_recv_o),
  .sof_recv_i  (sof_recv_o),
  .pkt_valid_i (pkt_valid_o)
);

// ==== test/ulpi_rx_tb.sv ====
`timescale 1ns/1ps
`include "usb_rx_defs.svh"

module ulpi_rx_tb;

  localparam int TIMEOUT = 50;
  localparam int S_NONE  = 0;
  localparam int S_TOK   = 1;
  localparam int S_SOF   = 2;
  localparam int S_HSK   = 3;
  localparam int S_ERR   = 4;
  localparam int S_PKT   = 5;
  localparam int S_IDLE  = 6;

  logic                       clock;
  logic                       reset;
  logic                       ulpi_dir;
  logic                       ulpi_nxt;
  logic [7:0]                 ulpi_data;
  logic [`ULPI_RX_BUF_AW-1:0] rd_addr;
  logic [7:0]                 rd_data;
  logic                       tok_recv;
  logic                       sof_recv;
  logic                       hsk_recv;
  logic                       crc_error;
  logic                       crc_valid;
  logic                       decode_idle;
  logic                       pkt_valid;

  usb_rx_pkg::phy_status_t   phy_status;
  usb_rx_pkg::usb_token_t    token;
  usb_rx_pkg::usb_pid_e      hsk_pid;
  usb_rx_pkg::usb_pkt_info_t pkt_info;

  // Bytes of the packet the PHY model sends next
  logic [7:0]  tx_buf [128];
  logic [31:0] rng_state;
  int          errors;
  int          checks;

  // The decoder's copy already set the header guard
  `undef USB_CRC_SVH
  `include "usb_crc.svh"

  initial clock = 1'b0;
  always #4 clock = ~clock;

  ulpi_rx_top u_dut (
    .clock         (clock),
    .reset         (reset),
    .ulpi_dir_i    (ulpi_dir),
    .ulpi_nxt_i    (ulpi_nxt),
    .ulpi_data_i   (ulpi_data),
    .phy_status_o  (phy_status),
    .token_o       (token),
    .tok_recv_o    (tok_recv),
    .sof_recv_o    (sof_recv),
    .hsk_recv_o    (hsk_recv),
    .hsk_pid_o     (hsk_pid),
    .crc_error_o   (crc_error),
    .crc_valid_o   (crc_valid),
    .decode_idle_o (decode_idle),
    .pkt_valid_o   (pkt_valid),
    .pkt_info_o    (pkt_info),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // PID in the low nibble, its complement in the high nibble
  function automatic logic [7:0] pid_byte(input usb_rx_pkg::usb_pid_e pid);
    logic [3:0] p;
    p = pid;
    return {~p, p};
  endfunction

  function automatic logic strobe_level(input int which);
    case (which)
      S_TOK:   return tok_recv;
      S_SOF:   return sof_recv;
      S_HSK:   return hsk_recv;
      S_ERR:   return crc_error;
      S_PKT:   return pkt_valid;
      S_IDLE:  return decode_idle;
      default: return 1'b0;
    endcase
  endfunction

  function automatic string strobe_name(input int which);
    case (which)
      S_TOK:   return "tok_recv_o";
      S_SOF:   return "sof_recv_o";
      S_HSK:   return "hsk_recv_o";
      S_ERR:   return "crc_error_o";
      S_PKT:   return "pkt_valid_o";
      S_IDLE:  return "decode_idle_o";
      default: return "none";
    endcase
  endfunction

  task automatic check_token(input string test, input usb_rx_pkg::usb_token_t exp,
                             input usb_rx_pkg::usb_token_t act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: token expected %h, got %h", test, exp, act);
      errors++;
    end
  endtask

  task automatic check_pkt_info(input string test, input usb_rx_pkg::usb_pkt_info_t exp,
                                input usb_rx_pkg::usb_pkt_info_t act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: packet info expected %h, got %h", test, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input string test, input usb_rx_pkg::phy_status_t exp,
                              input usb_rx_pkg::phy_status_t act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: status expected %h, got %h", test, exp, act);
      errors++;
    end
  endtask

  task automatic check_pid(input string test, input usb_rx_pkg::usb_pid_e exp,
                           input usb_rx_pkg::usb_pid_e act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: pid expected %h, got %h", test, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: byte expected %h, got %h", test, exp, act);
      errors++;
    end
  endtask

  // Sample at the falling edge, where the registered outputs are settled
  task automatic wait_strobe(input string test, input int which, input int forbid,
                             output bit seen);
    int cyc;
    seen = 1'b0;
    cyc = 0;
    while (!seen && cyc < TIMEOUT) begin
      @(negedge clock);
      if (strobe_level(forbid)) begin
        $display("%s: %s went high but should have stayed low", test, strobe_name(forbid));
        errors++;
      end
      seen = strobe_level(which);
      cyc++;
    end
    if (!seen) begin
      $display("%s: timed out waiting, %s never came", test, strobe_name(which));
      errors++;
    end
  endtask

  task automatic expect_quiet(input string test, input int which, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clock);
      if (strobe_level(which)) begin
        $display("%s: %s went high but should have stayed low", test, strobe_name(which));
        errors++;
      end
    end
  endtask

  // PHY model: turnaround, RxActive, bytes with nxt, end RX_CMD, release
  task automatic send_packet(input int n);
    @(posedge clock);
    ulpi_dir  <= 1'b1;
    ulpi_nxt  <= 1'b0;
    ulpi_data <= 8'h00;
    @(posedge clock);
    ulpi_data <= {2'b00, `ULPI_RXCMD_ACTIVE, 4'hd};
    for (int i = 0; i < n; i++) begin
      @(posedge clock);
      ulpi_nxt  <= 1'b1;
      ulpi_data <= tx_buf[i];
    end
    @(posedge clock);
    ulpi_nxt  <= 1'b0;
    ulpi_data <= 8'h0d;
    @(posedge clock);
    ulpi_dir  <= 1'b0;
    ulpi_data <= 8'h00;
  endtask

  // Token layout: addr in bits 6:0, endp in 10:7, CRC5 on top
  task automatic load_token(input usb_rx_pkg::usb_pid_e pid, input logic [10:0] bits);
    logic [4:0] c;
    c = crc5(bits);
    tx_buf[0] = pid_byte(pid);
    tx_buf[1] = bits[7:0];
    tx_buf[2] = {c, bits[10:8]};
  endtask

  task automatic load_data(input usb_rx_pkg::usb_pid_e pid, input int n);
    logic [15:0] c;
    logic [31:0] r;
    tx_buf[0] = pid_byte(pid);
    c = 16'hffff;
    for (int i = 1; i <= n; i++) begin
      r = next_random();
      tx_buf[i] = r[7:0];
      c = crc16(r[7:0], c);
    end
    tx_buf[n + 1] = ~c[7:0];
    tx_buf[n + 2] = ~c[15:8];
  endtask

  task automatic test_status();
    usb_rx_pkg::phy_status_t exp;
    exp.line_state = 2'b10;
    exp.vbus_state = 2'b11;
    exp.rx_event   = 2'b10;
    @(posedge clock);
    ulpi_dir  <= 1'b1;
    ulpi_nxt  <= 1'b0;
    ulpi_data <= 8'h00;
    @(posedge clock);
    ulpi_data <= {2'b00, exp.rx_event, exp.vbus_state, exp.line_state};
    @(posedge clock);
    ulpi_dir  <= 1'b0;
    ulpi_data <= 8'h00;
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_status("rx_cmd_status", exp, phy_status);
  endtask

  task automatic test_token(input string test, input usb_rx_pkg::usb_pid_e pid);
    logic [31:0]            r;
    usb_rx_pkg::usb_token_t exp;
    bit                     seen;
    r = next_random();
    exp.pid  = pid;
    exp.addr = r[6:0];
    exp.endp = r[10:7];
    load_token(pid, r[10:0]);
    send_packet(3);
    wait_strobe(test, (pid == usb_rx_pkg::PID_SOF) ? S_SOF : S_TOK, S_ERR, seen);
    if (seen) begin
      check_token(test, exp, token);
      if (!crc_valid) begin
        $display("%s: crc_valid_o was low with the token strobe", test);
        errors++;
      end
    end
  endtask

  task automatic test_bad_token();
    logic [31:0] r;
    bit          seen;
    r = next_random();
    load_token(usb_rx_pkg::PID_OUT, r[10:0]);
    // One CRC5 bit flipped
    tx_buf[2][3 + (r[31:16] % 5)] = ~tx_buf[2][3 + (r[31:16] % 5)];
    send_packet(3);
    wait_strobe("bad_token_crc", S_ERR, S_TOK, seen);
    expect_quiet("bad_token_crc", S_TOK, 4);
  endtask

  task automatic test_data_good();
    int                        n;
    logic [31:0]               r;
    usb_rx_pkg::usb_pkt_info_t exp;
    bit                        seen;
    r = next_random();
    n = 1 + r % 60;
    load_data(usb_rx_pkg::PID_DATA1, n);
    exp.pid    = usb_rx_pkg::PID_DATA1;
    exp.length = n[`ULPI_RX_BUF_AW:0];
    send_packet(n + 3);
    wait_strobe("data1_good", S_PKT, S_ERR, seen);
    if (seen) begin
      check_pkt_info("data1_good", exp, pkt_info);
      for (int i = 0; i < n; i++) begin
        @(posedge clock);
        rd_addr <= i[`ULPI_RX_BUF_AW-1:0];
        @(posedge clock);
        @(negedge clock);
        check_byte("data1_good", tx_buf[i + 1], rd_data);
      end
    end
  endtask

  task automatic test_data_corrupt();
    int          n;
    int          idx;
    logic [31:0] r;
    bit          seen;
    r = next_random();
    n = 1 + r % 60;
    load_data(usb_rx_pkg::PID_DATA0, n);
    r = next_random();
    idx = 1 + r % n;
    tx_buf[idx] = tx_buf[idx] ^ (r[15:8] | 8'h01);
    send_packet(n + 3);
    wait_strobe("data0_corrupt", S_ERR, S_PKT, seen);
    expect_quiet("data0_corrupt", S_PKT, 4);
  endtask

  task automatic test_handshake(input string test, input usb_rx_pkg::usb_pid_e pid);
    bit seen;
    tx_buf[0] = pid_byte(pid);
    send_packet(1);
    wait_strobe(test, S_HSK, S_ERR, seen);
    if (seen) begin
      check_pid(test, pid, hsk_pid);
    end
    wait_strobe(test, S_IDLE, S_NONE, seen);
  endtask

  initial begin
    rng_state = 32'd86;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    ulpi_dir  = 1'b0;
    ulpi_nxt  = 1'b0;
    ulpi_data = 8'h00;
    rd_addr   = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_status("reset", '0, phy_status);

    test_status();
    test_token("in_token", usb_rx_pkg::PID_IN);
    test_token("sof_token", usb_rx_pkg::PID_SOF);
    test_bad_token();
    test_data_good();
    test_data_corrupt();
    test_handshake("handshake_ack", usb_rx_pkg::PID_ACK);
    test_handshake("handshake_stall", usb_rx_pkg::PID_STALL);

    repeat (4) @(posedge clock);
    errors += u_dut.u_assertions.fail_count;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== ulpi_rx_top.f ====
+incdir+logic
logic/usb_rx_pkg.sv
logic/ulpi_phy_input.sv
logic/ulpi_decoder.sv
logic/usb_packet_buffer.sv
logic/ulpi_rx_top.sv
test/ulpi_rx_assertions.sv
test/ulpi_rx_tb.sv
